//--- hdl/init_table.hex
// register address (16 bits) then value (8 bits), one entry per line
301280
30080a
303501
3036a4
380c06
380e03
4300d3
501f00

//--- cam_link_top.f
hdl/cam_link_pkg.sv
hdl/cam_ctrl_regs.sv
hdl/sccb_init_writer.sv
hdl/frame_end_stuffer.sv
hdl/cam_link_top.sv
test/cam_link_chk.sv
test/cam_link_monitor.sv
test/cam_link_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f cam_link_top.f --top-module cam_link_tb -o sim
	./obj_dir/sim 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG) || ! grep -q "Simulation PASSED" $(LOG); then \
		echo "test failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- test/cam_link_tb.sv
`timescale 1ns/1ps

module cam_link_tb;
    import cam_link_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int FRAME_CYCLES = 48;
    localparam int FRAMES = 4;
    localparam int INIT_CYCLES = INIT_ENTRIES * 38 * 4 * (int'(DIV_DEFAULT) + 1);
    localparam int STREAM_CYCLES = FRAMES * (FRAME_CYCLES + 16) + 400;
    localparam int LIMIT_CYCLES = 2 * (RESET_CYCLES + INIT_CYCLES + STREAM_CYCLES);

    logic        clock;
    logic        reset;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    pix_t        pix_in;
    pix_t        pix_out;
    logic        scl;
    logic        sda;
    logic        stream_check;
    logic [16:0] lfsr_q;

    cam_link_top dut (
        .clock    (clock),
        .reset    (reset),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp),
        .pix_i    (pix_in),
        .pix_o    (pix_out),
        .scl_o    (scl),
        .sda_o    (sda)
    );

    cam_link_monitor mon (
        .clock      (clock),
        .reset      (reset),
        .check_en_i (stream_check),
        .wb_req_i   (wb_req),
        .wb_rsp_i   (wb_rsp),
        .pix_in_i   (pix_in),
        .pix_out_i  (pix_out),
        .scl_i      (scl),
        .sda_i      (sda)
    );

    bind cam_link_top cam_link_chk chk (
        .clock       (clock),
        .reset       (reset),
        .ack_i       (wb_rsp_o.ack),
        .cyc_i       (wb_req_i.cyc),
        .stb_i       (wb_req_i.stb),
        .busy_i      (init_stat.busy),
        .out_valid_i (pix_o.valid),
        .in_delim_i  (u_stuff.state == cam_link_pkg::ST_DELIM)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////
    // helpers
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};    // x^17 + x^14 + 1
    endfunction

    task automatic get_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_q[16]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic wb_cycle(input logic we, input logic [WB_ADR_W-1:0] adr,
                            input logic [WB_DAT_W-1:0] dat, output logic [WB_DAT_W-1:0] rdat);
        int waited;
        waited = 0;
        @(negedge clock);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(negedge clock);
        while (!wb_rsp.ack && waited < 16) begin
            @(negedge clock);
            waited++;
        end
        if (!wb_rsp.ack) mon.note_failure("wishbone request got no ack");
        rdat = wb_rsp.dat;
        @(negedge clock);    // hold through the ack cycle
        wb_req = '0;
    endtask

    task automatic write_reg(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat);
        logic [WB_DAT_W-1:0] unused;
        wb_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic expect_reg(input string name, input logic [WB_ADR_W-1:0] adr,
                              input logic [WB_DAT_W-1:0] exp);
        logic [WB_DAT_W-1:0] rdat;
        wb_cycle(1'b0, adr, '0, rdat);
        mon.check_value(name, exp, rdat);
    endtask

    // one frame of random bytes, then the falling sync and blanking
    task automatic send_frame();
        logic [7:0] v;
        logic [7:0] d;
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            @(negedge clock);
            get_bits(1, v);
            get_bits(8, d);
            pix_in = '{valid: v[0], vsync: 1'b1, data: d};
        end
        @(negedge clock);
        get_bits(1, v);
        get_bits(8, d);
        pix_in = '{valid: v[0], vsync: 1'b0, data: d};
        for (int i = 0; i < DELIM_BYTES + 6; i++) begin
            @(negedge clock);
            get_bits(1, v);
            get_bits(8, d);
            pix_in = '{valid: (i >= DELIM_BYTES) ? v[0] : 1'b0, vsync: 1'b0, data: d};
        end
        @(negedge clock);
        pix_in = '0;
    endtask

    initial begin
        #(LIMIT_CYCLES * 4);
        $display("timeout: run did not finish within %0d clock cycles", LIMIT_CYCLES);
        mon.report_counts();
        $display("Simulation FAILED");
        $finish;
    end

    ////////////////////
    // test sequence
    initial begin
        logic [WB_DAT_W-1:0] stat;
        reset = 1'b1;
        wb_req = '0;
        pix_in = '0;
        stream_check = 1'b0;
        lfsr_q = 17'd91197;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // reset values
        expect_reg("STATUS", REG_STATUS, 32'h0);
        expect_reg("DELIM", REG_DELIM, 32'h0000ffd9);
        expect_reg("DIV", REG_DIV, 32'h3);
        mon.check_value("scl_o", 32'd1, 32'(scl));
        mon.check_value("sda_o", 32'd1, 32'(sda));
        mon.check_value("pix_o.valid", 32'd0, 32'(pix_out.valid));

        // register round trip
        write_reg(REG_DIV, 32'h5);
        expect_reg("DIV", REG_DIV, 32'h5);
        write_reg(REG_STATUS, 32'h3);
        expect_reg("STATUS", REG_STATUS, 32'h0);
        write_reg(REG_DIV, 32'h3);

        // live input during init, the output must stay idle
        pix_in = '{valid: 1'b1, vsync: 1'b0, data: 8'ha5};

        // init run, second start while busy must be ignored
        write_reg(REG_CTRL, 32'h1);
        expect_reg("STATUS", REG_STATUS, 32'h1);
        write_reg(REG_CTRL, 32'h1);
        stat = '0;
        while (!stat[1]) begin
            wb_cycle(1'b0, REG_STATUS, '0, stat);
        end
        pix_in = '0;
        expect_reg("STATUS", REG_STATUS, 32'h2);
        mon.check_value("i2c transactions", 32'd8, 32'(mon.txn_count));
        mon.check_value("scl_o", 32'd1, 32'(scl));
        mon.check_value("sda_o", 32'd1, 32'(sda));

        // stream with default then new delimiter
        @(negedge clock);
        stream_check = 1'b1;
        for (int f = 0; f < FRAMES / 2; f++) send_frame();
        write_reg(REG_DELIM, 32'h1234);
        expect_reg("DELIM", REG_DELIM, 32'h1234);
        for (int f = 0; f < FRAMES / 2; f++) send_frame();
        repeat (4) @(negedge clock);
        stream_check = 1'b0;

        repeat (4) @(negedge clock);
        mon.report_counts();
        if (mon.error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- test/cam_link_monitor.sv
`timescale 1ns/1ps

module cam_link_monitor (
    input logic                  clock,
    input logic                  reset,
    input logic                  check_en_i,    // stream compare enable
    input cam_link_pkg::wb_req_t wb_req_i,
    input cam_link_pkg::wb_rsp_t wb_rsp_i,
    input cam_link_pkg::pix_t    pix_in_i,
    input cam_link_pkg::pix_t    pix_out_i,
    input logic                  scl_i,
    input logic                  sda_i
);
    import cam_link_pkg::*;

    logic [ENTRY_W-1:0]       table_rom [INIT_ENTRIES];
    int                       error_count = 0;
    int                       check_count = 0;
    int                       txn_count = 0;
    logic [DELIM_BYTES*8-1:0] delim_shadow;
    logic                     prev_vs;
    int                       delim_pos;    // 0 passes through, k emits delimiter byte k-1
    pix_t                     exp_pix;
    logic                     armed;
    logic                     scl_q;
    logic                     sda_q;
    logic                     in_txn;
    int                       bit_cnt;
    int                       byte_cnt;
    logic [7:0]               shift;

    initial begin
        $readmemh("hdl/init_table.hex", table_rom);
    end

    ////////////////////
    // reference model
    function automatic logic [7:0] ref_i2c_byte(input int txn, input int k);
        logic [ENTRY_W-1:0] e;
        e = table_rom[txn];
        case (k)
            0:       return 8'h48;    // sensor 7'h24, write
            1:       return e[23:16];
            2:       return e[15:8];
            default: return e[7:0];
        endcase
    endfunction

    function automatic pix_t ref_pix(input pix_t in, input logic prev, input int pos,
                                     input logic [DELIM_BYTES*8-1:0] delim);
        pix_t r;
        if (pos > 0) begin
            r = '{valid: 1'b1, vsync: 1'b1, data: delim[(DELIM_BYTES - pos) * 8 +: 8]};
        end else begin
            r = in;
            if (prev && !in.vsync) begin
                r.vsync = 1'b1;    // sync stays high on its falling edge
            end
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s expected 0x%h got 0x%h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic note_failure(input string what);
        error_count++;
        $display("error: %s at %0t", what, $time);
    endtask

    task automatic report_counts();
        $display("checks %0d, errors %0d, i2c transactions %0d",
                 check_count, error_count, txn_count);
    endtask

    // delimiter register as seen on the bus
    always @(posedge clock) begin
        if (reset) begin
            delim_shadow <= 16'hffd9;
        end else if (wb_rsp_i.ack && wb_req_i.cyc && wb_req_i.stb && wb_req_i.we
                     && wb_req_i.adr == REG_DELIM) begin
            delim_shadow <= wb_req_i.dat[DELIM_BYTES*8-1:0];
        end
    end

    ////////////////////
    // stream compare
    always @(posedge clock) begin
        if (reset || !check_en_i) begin
            prev_vs   <= 1'b0;
            delim_pos <= 0;
            armed     <= 1'b0;
        end else begin
            exp_pix <= ref_pix(pix_in_i, prev_vs, delim_pos, delim_shadow);
            armed   <= 1'b1;
            prev_vs <= pix_in_i.vsync;
            if (delim_pos == 0) begin
                if (prev_vs && !pix_in_i.vsync) delim_pos <= 1;
            end else if (delim_pos == DELIM_BYTES) begin
                delim_pos <= 0;
            end else begin
                delim_pos <= delim_pos + 1;
            end
        end
    end

    always @(negedge clock) begin
        if (armed && check_en_i) check_value("pix_o", 32'(exp_pix), 32'(pix_out_i));
    end

    ////////////////////
    // i2c decoder
    always @(posedge clock) begin
        if (reset) begin
            scl_q  <= 1'b1;
            sda_q  <= 1'b1;
            in_txn <= 1'b0;
        end else begin
            scl_q <= scl_i;
            sda_q <= sda_i;
            if (scl_q && scl_i && sda_q && !sda_i) begin    // start
                in_txn   <= 1'b1;
                bit_cnt  <= 0;
                byte_cnt <= 0;
            end else if (scl_q && scl_i && !sda_q && sda_i) begin    // stop
                if (!in_txn) begin
                    note_failure("i2c stop seen without a start");
                end else begin
                    check_value("i2c bytes per transaction", 32'd4, 32'(byte_cnt));
                end
                txn_count <= txn_count + 1;
                in_txn    <= 1'b0;
            end else if (!scl_q && scl_i && in_txn) begin
                if (bit_cnt < 8) begin
                    shift   <= {shift[6:0], sda_i};
                    bit_cnt <= bit_cnt + 1;
                end else begin
                    check_value("sda_o ack slot", 32'd1, 32'(sda_i));
                    if (txn_count >= INIT_ENTRIES) begin
                        note_failure("extra i2c transaction after the table end");
                    end else begin
                        check_value("i2c byte", 32'(ref_i2c_byte(txn_count, byte_cnt)),
                                    32'(shift));
                    end
                    byte_cnt <= byte_cnt + 1;
                    bit_cnt  <= 0;
                end
            end
        end
    end

endmodule

//--- test/cam_link_chk.sv
`timescale 1ns/1ps

module cam_link_chk (
    input logic clock,
    input logic reset,
    input logic ack_i,
    input logic cyc_i,
    input logic stb_i,
    input logic busy_i,
    input logic out_valid_i,
    input logic in_delim_i
);
    import cam_link_pkg::*;

    int run_len;    // cycles spent in the delimiter state

    always_ff @(posedge clock) begin
        if (reset) begin
            run_len <= 0;
        end else begin
            run_len <= in_delim_i ? run_len + 1 : 0;
        end
    end

    ////////////////////
    ap_ack_with_req: assert property (@(posedge clock) disable iff (reset)
        ack_i |-> cyc_i && stb_i)
        else $error("ack seen without cyc and stb");

    ap_ack_one_cycle: assert property (@(posedge clock) disable iff (reset)
        ack_i |=> !ack_i)
        else $error("ack held longer than one cycle");

    // stuffer sits in reset while the sensor is being set up
    ap_quiet_busy: assert property (@(posedge clock) disable iff (reset)
        busy_i && $past(busy_i) |-> !out_valid_i)
        else $error("stream output valid while initializer busy");

    ap_delim_len: assert property (@(posedge clock) disable iff (reset)
        $fell(in_delim_i) |-> run_len == DELIM_BYTES)
        else $error("delimiter run has the wrong length");

endmodule

//--- hdl/cam_link_top.sv
`timescale 1ns/1ps

module cam_link_top (
    input  logic                  clock,
    input  logic                  reset,
    input  cam_link_pkg::wb_req_t wb_req_i,
    output cam_link_pkg::wb_rsp_t wb_rsp_o,
    input  cam_link_pkg::pix_t    pix_i,
    output cam_link_pkg::pix_t    pix_o,
    output logic                  scl_o,
    output logic                  sda_o
);
    import cam_link_pkg::*;

    init_cfg_t                init_cfg;
    init_stat_t               init_stat;
    logic [DELIM_BYTES*8-1:0] delim;
    logic                     stuff_reset;

    // framing stays quiet until the sensor is configured
    assign stuff_reset = reset | init_stat.busy;

    ////////////////////
    // control registers
    cam_ctrl_regs u_regs (
        .clock       (clock),
        .reset       (reset),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .init_stat_i (init_stat),
        .init_cfg_o  (init_cfg),
        .delim_o     (delim)
    );

    ////////////////////
    // sensor init over i2c
    sccb_init_writer u_init (
        .clock       (clock),
        .reset       (reset),
        .init_cfg_i  (init_cfg),
        .init_stat_o (init_stat),
        .scl_o       (scl_o),
        .sda_o       (sda_o)
    );

    ////////////////////
    // frame end delimiter
    frame_end_stuffer u_stuff (
        .clock   (clock),
        .reset   (stuff_reset),
        .delim_i (delim),
        .pix_i   (pix_i),
        .pix_o   (pix_o)
    );

endmodule

//--- hdl/frame_end_stuffer.sv
`timescale 1ns/1ps

module frame_end_stuffer (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [cam_link_pkg::DELIM_BYTES*8-1:0] delim_i,
    input  cam_link_pkg::pix_t                     pix_i,
    output cam_link_pkg::pix_t                     pix_o
);
    import cam_link_pkg::*;

    stuff_state_e           state;
    logic [DELIM_IDX_W-1:0] delim_idx;
    logic                   vsync_prev;
    logic                   sync_fall;
    logic [DATA_W-1:0]      delim_byte;
    logic                   valid_q;
    logic                   vsync_q;
    logic [DATA_W-1:0]      data_q;

    assign sync_fall  = vsync_prev & ~pix_i.vsync;
    // msb byte of the delimiter goes out first
    assign delim_byte = delim_i[(DELIM_BYTES - 1 - int'(delim_idx)) * DATA_W +: DATA_W];

    ////////////////////
    // state and flags
    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= ST_IMAGE;
            delim_idx  <= '0;
            vsync_prev <= 1'b0;
            valid_q    <= 1'b0;
            vsync_q    <= 1'b0;
        end else begin
            vsync_prev <= pix_i.vsync;
            unique case (state)
                ST_IMAGE: begin
                    valid_q   <= pix_i.valid;
                    vsync_q   <= pix_i.vsync | sync_fall;    // stretch sync over the edge
                    delim_idx <= '0;
                    if (sync_fall) begin
                        state <= ST_DELIM;
                    end
                end
                default: begin
                    valid_q <= 1'b1;
                    vsync_q <= 1'b1;
                    if (delim_idx == DELIM_IDX_W'(DELIM_BYTES - 1)) begin
                        delim_idx <= '0;
                        state     <= ST_IMAGE;
                    end else begin
                        delim_idx <= delim_idx + 1'b1;
                    end
                end
            endcase
        end
    end

    // input bytes during the delimiter are dropped
    always_ff @(posedge clock) begin
        data_q <= (state == ST_DELIM) ? delim_byte : pix_i.data;
    end

    assign pix_o = '{valid: valid_q, vsync: vsync_q, data: data_q};

endmodule

//--- hdl/sccb_init_writer.sv
`timescale 1ns/1ps

module sccb_init_writer (
    input  logic                     clock,
    input  logic                     reset,
    input  cam_link_pkg::init_cfg_t  init_cfg_i,
    output cam_link_pkg::init_stat_t init_stat_o,
    output logic                     scl_o,
    output logic                     sda_o
);
    import cam_link_pkg::*;

    logic [ENTRY_W-1:0]     rom [INIT_ENTRIES];

    init_phase_e            phase;
    logic [DIV_W-1:0]       tick_cnt;
    logic                   tick;
    logic [1:0]             quarter;      // quarter within a bit slot
    logic [ENTRY_IDX_W-1:0] entry_idx;
    logic [1:0]             byte_idx;     // 0 is the device byte
    logic [3:0]             bit_idx;      // 8 is the ack slot
    logic [ENTRY_W-1:0]     entry;
    logic [7:0]             cur_byte;
    logic                   cur_bit;
    logic                   busy_q;
    logic                   done_q;

    initial begin
        $readmemh("hdl/init_table.hex", rom);
    end

    assign entry = rom[entry_idx];
    assign tick  = (tick_cnt >= init_cfg_i.div);    // >= copes with a div lowered mid-run

    always_comb begin
        unique case (byte_idx)
            2'd0:    cur_byte = {DEV_ADDR, 1'b0};    // write
            2'd1:    cur_byte = entry[ENTRY_W-1 -: 8];
            2'd2:    cur_byte = entry[ENTRY_W-9 -: 8];
            default: cur_byte = entry[7:0];
        endcase
        // msb first, sda released in the ack slot
        cur_bit = (bit_idx == 4'd8) ? 1'b1 : cur_byte[~bit_idx[2:0]];
    end

    // quarter-bit pacing
    always_ff @(posedge clock) begin
        if (reset || phase == PH_IDLE || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    ////////////////////
    // bit sequencer
    always_ff @(posedge clock) begin
        if (reset) begin
            phase     <= PH_IDLE;
            quarter   <= '0;
            entry_idx <= '0;
            byte_idx  <= '0;
            bit_idx   <= '0;
            scl_o     <= 1'b1;
            sda_o     <= 1'b1;
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            unique case (phase)
                PH_IDLE: begin
                    if (init_cfg_i.start) begin
                        phase     <= PH_START;
                        quarter   <= '0;
                        entry_idx <= '0;
                        busy_q    <= 1'b1;
                        done_q    <= 1'b0;
                    end
                end
                PH_START: begin
                    if (tick) begin
                        quarter <= quarter + 1'b1;
                        unique case (quarter)
                            2'd1: sda_o <= 1'b0;    // start, scl still high
                            2'd2: scl_o <= 1'b0;
                            2'd3: begin
                                phase    <= PH_BITS;
                                byte_idx <= '0;
                                bit_idx  <= '0;
                            end
                            default: ;
                        endcase
                    end
                end
                PH_BITS: begin
                    if (tick) begin
                        quarter <= quarter + 1'b1;
                        unique case (quarter)
                            2'd0: sda_o <= cur_bit;    // change data while scl low
                            2'd1: scl_o <= 1'b1;
                            2'd3: begin
                                scl_o <= 1'b0;
                                if (bit_idx == 4'd8) begin
                                    bit_idx  <= '0;
                                    byte_idx <= byte_idx + 1'b1;
                                    if (byte_idx == 2'd3) begin
                                        phase <= PH_STOP;
                                    end
                                end else begin
                                    bit_idx <= bit_idx + 1'b1;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                PH_STOP: begin
                    if (tick) begin
                        quarter <= quarter + 1'b1;
                        unique case (quarter)
                            2'd0: sda_o <= 1'b0;
                            2'd1: scl_o <= 1'b1;
                            2'd2: sda_o <= 1'b1;    // stop, scl high
                            default: begin
                                if (entry_idx == ENTRY_IDX_W'(INIT_ENTRIES - 1)) begin
                                    phase <= PH_DONE;
                                end else begin
                                    entry_idx <= entry_idx + 1'b1;
                                    phase     <= PH_START;
                                end
                            end
                        endcase
                    end
                end
                PH_DONE: begin
                    phase  <= PH_IDLE;
                    busy_q <= 1'b0;
                    done_q <= 1'b1;    // held until the next start
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    assign init_stat_o = '{busy: busy_q, done: done_q};

endmodule

//--- hdl/cam_ctrl_regs.sv
`timescale 1ns/1ps

module cam_ctrl_regs (
    input  logic                                   clock,
    input  logic                                   reset,
    input  cam_link_pkg::wb_req_t                  wb_req_i,
    output cam_link_pkg::wb_rsp_t                  wb_rsp_o,
    input  cam_link_pkg::init_stat_t               init_stat_i,
    output cam_link_pkg::init_cfg_t                init_cfg_o,
    output logic [cam_link_pkg::DELIM_BYTES*8-1:0] delim_o
);
    import cam_link_pkg::*;

    logic                     ack_q;
    logic [WB_DAT_W-1:0]      rd_dat_q;
    logic [DELIM_BYTES*8-1:0] delim_q;
    logic [DIV_W-1:0]         div_q;
    logic                     start_q;
    logic                     req_new;
    logic                     wr_en;
    reg_addr_e                addr;

    assign addr    = reg_addr_e'(wb_req_i.adr);
    assign req_new = wb_req_i.cyc & wb_req_i.stb & ~ack_q;    // first cycle of a request
    // master holds the request through the ack cycle
    assign wr_en   = ack_q & wb_req_i.cyc & wb_req_i.stb & wb_req_i.we;

    always_ff @(posedge clock) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_new;
        end
    end

    // read data lines up with ack
    always_ff @(posedge clock) begin
        if (req_new) begin
            unique case (addr)
                REG_STATUS: rd_dat_q <= WB_DAT_W'({init_stat_i.done, init_stat_i.busy});
                REG_DELIM:  rd_dat_q <= WB_DAT_W'(delim_q);
                REG_DIV:    rd_dat_q <= WB_DAT_W'(div_q);
                default:    rd_dat_q <= '0;    // ctrl is write only
            endcase
        end
    end

    ////////////////////
    // writable registers
    always_ff @(posedge clock) begin
        if (reset) begin
            delim_q <= DELIM_DEFAULT;
            div_q   <= DIV_DEFAULT;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (wr_en) begin
                unique case (addr)
                    REG_CTRL:  start_q <= wb_req_i.dat[0] & ~init_stat_i.busy;
                    REG_DELIM: delim_q <= wb_req_i.dat[DELIM_BYTES*8-1:0];
                    REG_DIV:   div_q   <= wb_req_i.dat[DIV_W-1:0];
                    default:   ;    // status ignores writes
                endcase
            end
        end
    end

    assign wb_rsp_o   = '{ack: ack_q, dat: rd_dat_q};
    assign init_cfg_o = '{start: start_q, div: div_q};
    assign delim_o    = delim_q;

endmodule

//--- hdl/cam_link_pkg.sv
package cam_link_pkg;

    ////////////////////
    // widths and defaults
    localparam int DATA_W = 8;
    localparam int DELIM_BYTES = 2;
    localparam logic [DELIM_BYTES*8-1:0] DELIM_DEFAULT = 16'hffd9;
    localparam logic [6:0] DEV_ADDR = 7'h24;    // 7-bit sensor address
    localparam int INIT_ENTRIES = 8;
    localparam int ENTRY_W = 24;                 // reg addr hi, reg addr lo, value
    localparam int DIV_W = 8;
    localparam logic [DIV_W-1:0] DIV_DEFAULT = 8'd3;
    localparam int WB_ADR_W = 2;
    localparam int WB_DAT_W = 32;

    // derived index widths
    localparam int ENTRY_IDX_W = $clog2(INIT_ENTRIES);
    localparam int DELIM_IDX_W = (DELIM_BYTES > 1) ? $clog2(DELIM_BYTES) : 1;

    ////////////////////
    // register map, word addresses
    typedef enum logic [WB_ADR_W-1:0] {
        REG_CTRL   = 2'd0,
        REG_STATUS = 2'd1,
        REG_DELIM  = 2'd2,
        REG_DIV    = 2'd3
    } reg_addr_e;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic              valid;
        logic              vsync;
        logic [DATA_W-1:0] data;
    } pix_t;

    typedef struct packed {
        logic             start;    // one-cycle pulse
        logic [DIV_W-1:0] div;
    } init_cfg_t;

    typedef struct packed {
        logic busy;
        logic done;
    } init_stat_t;

    typedef enum logic {ST_IMAGE, ST_DELIM} stuff_state_e;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_START,
        PH_BITS,
        PH_STOP,
        PH_DONE
    } init_phase_e;

endpackage
